// ==== logic/nice_pkg.sv ====
// nice coprocessor shared definitions

package nice_pkg;

   //////////////////////////////
   // widths
   //////////////////////////////
   localparam int XLEN = 32;

   // data word and memory address
   typedef logic [XLEN-1:0] word_t;
   typedef logic [31:0]     addr_t;

   // byte step between row words
   localparam int WORD_BYTES = 4;
   // icb size code for a full word
   localparam logic [1:0] ICB_SIZE_WORD = 2'b10;

   //////////////////////////////
   // row geometry
   //////////////////////////////
   localparam int ROW_LEN = 3;
   localparam int ROWBUF_DP = 4;

   // index into the row buffer
   typedef logic [1:0] row_idx_t;

   //////////////////////////////
   // custom3 instruction codes
   //////////////////////////////
   localparam logic [6:0] OPCODE_CUSTOM3 = 7'b1111011;

   localparam logic [2:0] FUNC3_LBUF   = 3'b010;
   localparam logic [2:0] FUNC3_SBUF   = 3'b010;
   localparam logic [2:0] FUNC3_ROWSUM = 3'b110;

   localparam logic [6:0] FUNC7_LBUF   = 7'b0000001;
   localparam logic [6:0] FUNC7_SBUF   = 7'b0000010;
   localparam logic [6:0] FUNC7_ROWSUM = 7'b0000110;

   // decoded operation, shared by every block
   typedef enum logic [1:0] {
      op_lbuf,
      op_sbuf,
      op_rowsum,
      op_illegal
   } nice_op_e;

   // controller states
   typedef enum logic [1:0] {
      st_idle,
      st_mem,
      st_rsp
   } nice_state_e;

endpackage

// ==== logic/nice_ctrl_fsm.sv ====
// nice instruction controller

`timescale 1ns/1ps

module nice_ctrl_fsm (
   input  logic               nice_clk,
   input  logic               reset,
   // cpu request
   input  logic               nice_req_valid,
   output logic               nice_req_ready,
   input  nice_pkg::word_t    nice_req_inst,
   input  nice_pkg::addr_t    nice_req_rs1,
   // cpu response
   output logic               nice_rsp_valid,
   input  logic               nice_rsp_ready,
   output nice_pkg::word_t    nice_rsp_rdat,
   output logic               nice_rsp_err,
   // status
   output logic               nice_active,
   output logic               nice_mem_holdup,
   // to memory agent and row buffer
   output logic               start,
   output nice_pkg::nice_op_e op,
   output nice_pkg::addr_t    base_addr,
   input  logic               done,
   input  logic               mem_err,
   input  nice_pkg::word_t    row_sum
);

   logic [6:0]            opcode;
   logic [2:0]            func3;
   logic [6:0]            func7;
   nice_pkg::nice_op_e    op_dec;
   nice_pkg::nice_op_e    op_q;
   nice_pkg::nice_state_e state_q;
   nice_pkg::addr_t       base_q;
   nice_pkg::word_t       rdat_q;
   logic                  err_q;
   logic                  start_q;
   logic                  req_hs;
   logic                  rsp_hs;

   //////////////////////////////
   // decode
   //////////////////////////////
   // r-type fields
   assign opcode = nice_req_inst[6:0];
   assign func3  = nice_req_inst[14:12];
   assign func7  = nice_req_inst[31:25];

   always_comb begin
      op_dec = nice_pkg::op_illegal;
      if (opcode == nice_pkg::OPCODE_CUSTOM3) begin
         // lbuf and sbuf share func3, func7 tells them apart
         if (func3 == nice_pkg::FUNC3_LBUF && func7 == nice_pkg::FUNC7_LBUF) begin
            op_dec = nice_pkg::op_lbuf;
         end else if (func3 == nice_pkg::FUNC3_SBUF && func7 == nice_pkg::FUNC7_SBUF) begin
            op_dec = nice_pkg::op_sbuf;
         end else if (func3 == nice_pkg::FUNC3_ROWSUM && func7 == nice_pkg::FUNC7_ROWSUM) begin
            op_dec = nice_pkg::op_rowsum;
         end
      end
   end

   //////////////////////////////
   // handshakes
   //////////////////////////////
   assign nice_req_ready = (state_q == nice_pkg::st_idle);
   assign req_hs         = nice_req_valid & nice_req_ready;
   assign rsp_hs         = nice_rsp_valid & nice_rsp_ready;

   //////////////////////////////
   // fsm
   //////////////////////////////
   always_ff @(posedge nice_clk) begin
      if (reset) begin
         state_q <= nice_pkg::st_idle;
         op_q    <= nice_pkg::op_illegal;
         start_q <= 1'b0;
      end else begin
         // start is a single cycle pulse
         start_q <= 1'b0;
         case (state_q)
            nice_pkg::st_idle: begin
               if (req_hs) begin
                  op_q <= op_dec;
                  // illegal op skips memory entirely
                  if (op_dec == nice_pkg::op_illegal) begin
                     state_q <= nice_pkg::st_rsp;
                  end else begin
                     state_q <= nice_pkg::st_mem;
                     start_q <= 1'b1;
                  end
               end
            end
            nice_pkg::st_mem: begin
               if (done) begin
                  state_q <= nice_pkg::st_rsp;
               end
            end
            nice_pkg::st_rsp: begin
               // hold until cpu takes it
               if (rsp_hs) begin
                  state_q <= nice_pkg::st_idle;
               end
            end
            default: begin
               state_q <= nice_pkg::st_idle;
            end
         endcase
      end
   end

   // request operands and response payload
   always_ff @(posedge nice_clk) begin
      if (req_hs) begin
         base_q <= nice_req_rs1;
         rdat_q <= '0;
         err_q  <= (op_dec == nice_pkg::op_illegal);
      end else if (done && state_q == nice_pkg::st_mem) begin
         // only rowsum returns data
         rdat_q <= (op_q == nice_pkg::op_rowsum) ? row_sum : '0;
         err_q  <= mem_err;
      end
   end

   //////////////////////////////
   // outputs
   //////////////////////////////
   assign start     = start_q;
   assign op        = op_q;
   assign base_addr = base_q;

   assign nice_rsp_valid  = (state_q == nice_pkg::st_rsp);
   assign nice_rsp_rdat   = rdat_q;
   assign nice_rsp_err    = err_q;
   assign nice_mem_holdup = (state_q == nice_pkg::st_mem);
   // active as soon as a request shows up
   assign nice_active     = (state_q == nice_pkg::st_idle) ? nice_req_valid : 1'b1;

endmodule

// ==== logic/nice_mem_agent.sv ====
// nice memory agent

`timescale 1ns/1ps

module nice_mem_agent (
   input  logic               nice_clk,
   input  logic               reset,
   // from controller
   input  logic               start,
   input  nice_pkg::nice_op_e op,
   input  nice_pkg::addr_t    base_addr,
   output logic               done,
   output logic               mem_err,
   // icb command
   output logic               nice_icb_cmd_valid,
   input  logic               nice_icb_cmd_ready,
   output nice_pkg::addr_t    nice_icb_cmd_addr,
   output logic               nice_icb_cmd_read,
   output nice_pkg::word_t    nice_icb_cmd_wdata,
   // icb response
   input  logic               nice_icb_rsp_valid,
   output logic               nice_icb_rsp_ready,
   input  nice_pkg::word_t    nice_icb_rsp_rdata,
   input  logic               nice_icb_rsp_err,
   // row buffer ports
   output logic               wr_en,
   output nice_pkg::row_idx_t wr_idx,
   output nice_pkg::word_t    wr_data,
   output nice_pkg::row_idx_t rd_idx,
   input  nice_pkg::word_t    rd_data
);

   localparam nice_pkg::row_idx_t CNT_FULL = nice_pkg::row_idx_t'(nice_pkg::ROW_LEN);
   localparam nice_pkg::row_idx_t CNT_LAST = nice_pkg::row_idx_t'(nice_pkg::ROW_LEN - 1);
   localparam nice_pkg::addr_t    ADDR_STEP = nice_pkg::addr_t'(nice_pkg::WORD_BYTES);

   logic               busy_q;
   nice_pkg::row_idx_t cmd_cnt_q;
   nice_pkg::row_idx_t rsp_cnt_q;
   nice_pkg::addr_t    addr_q;
   logic               done_q;
   logic               err_q;
   logic               cmd_hs;
   logic               rsp_hs;
   logic               rsp_last;

   //////////////////////////////
   // handshakes
   //////////////////////////////
   // responses always accepted
   assign nice_icb_rsp_ready = 1'b1;
   assign cmd_hs   = nice_icb_cmd_valid & nice_icb_cmd_ready;
   assign rsp_hs   = busy_q & nice_icb_rsp_valid & nice_icb_rsp_ready;
   assign rsp_last = rsp_hs & (rsp_cnt_q == CNT_LAST);

   //////////////////////////////
   // counters and status
   //////////////////////////////
   always_ff @(posedge nice_clk) begin
      if (reset) begin
         busy_q    <= 1'b0;
         cmd_cnt_q <= '0;
         rsp_cnt_q <= '0;
         done_q    <= 1'b0;
         err_q     <= 1'b0;
      end else begin
         done_q <= rsp_last;
         if (start) begin
            busy_q    <= 1'b1;
            cmd_cnt_q <= '0;
            rsp_cnt_q <= '0;
            err_q     <= 1'b0;
         end else begin
            if (cmd_hs) begin
               cmd_cnt_q <= cmd_cnt_q + 1'b1;
            end
            if (rsp_hs) begin
               rsp_cnt_q <= rsp_cnt_q + 1'b1;
               // sticky bus error for this instruction
               err_q     <= err_q | nice_icb_rsp_err;
            end
            if (rsp_last) begin
               busy_q <= 1'b0;
            end
         end
      end
   end

   // address walks the row one word per command
   always_ff @(posedge nice_clk) begin
      if (start) begin
         addr_q <= base_addr;
      end else if (cmd_hs) begin
         addr_q <= addr_q + ADDR_STEP;
      end
   end

   //////////////////////////////
   // outputs
   //////////////////////////////
   // commands run ahead of responses, up to a full row
   assign nice_icb_cmd_valid = busy_q & (cmd_cnt_q != CNT_FULL);
   assign nice_icb_cmd_addr  = addr_q;
   assign nice_icb_cmd_read  = (op != nice_pkg::op_sbuf);
   // sbuf data comes from the column being issued
   assign rd_idx             = cmd_cnt_q;
   assign nice_icb_cmd_wdata = rd_data;

   // read data goes straight into the row buffer
   assign wr_en   = rsp_hs & (op != nice_pkg::op_sbuf);
   assign wr_idx  = rsp_cnt_q;
   assign wr_data = nice_icb_rsp_rdata;

   assign done    = done_q;
   assign mem_err = err_q;

endmodule

// ==== logic/nice_rowbuf.sv ====
// nice row buffer

`timescale 1ns/1ps

module nice_rowbuf (
   input  logic               nice_clk,
   input  logic               reset,
   // instruction context
   input  logic               start,
   input  nice_pkg::nice_op_e op,
   // write port from memory responses
   input  logic               wr_en,
   input  nice_pkg::row_idx_t wr_idx,
   input  nice_pkg::word_t    wr_data,
   // read port for stores
   input  nice_pkg::row_idx_t rd_idx,
   output nice_pkg::word_t    rd_data,
   // running sum of words read
   output nice_pkg::word_t    row_sum
);

   nice_pkg::word_t buf_q [nice_pkg::ROWBUF_DP];
   nice_pkg::word_t sum_q;
   logic            is_lbuf;
   logic            is_rowsum;

   assign is_lbuf   = (op == nice_pkg::op_lbuf);
   assign is_rowsum = (op == nice_pkg::op_rowsum);

   //////////////////////////////
   // storage
   //////////////////////////////
   always_ff @(posedge nice_clk) begin
      if (wr_en) begin
         if (is_lbuf) begin
            // lbuf overwrites the column
            buf_q[wr_idx] <= wr_data;
         end else if (is_rowsum) begin
            // rowsum adds into the column, wraps mod 2^32
            buf_q[wr_idx] <= buf_q[wr_idx] + wr_data;
         end
      end
   end

   //////////////////////////////
   // row sum accumulator
   //////////////////////////////
   always_ff @(posedge nice_clk) begin
      if (reset) begin
         sum_q <= '0;
      end else if (start) begin
         // fresh sum per instruction
         sum_q <= '0;
      end else if (wr_en && is_rowsum) begin
         sum_q <= sum_q + wr_data;
      end
   end

   //////////////////////////////
   // outputs
   //////////////////////////////
   // combinational read by index
   assign rd_data = buf_q[rd_idx];
   assign row_sum = sum_q;

endmodule

// ==== logic/nice_core.sv ====
// nice coprocessor top

`timescale 1ns/1ps

module nice_core (
   // system
   input  logic            nice_clk,
   input  logic            reset,
   output logic            nice_active,
   output logic            nice_mem_holdup,
   // cpu request
   input  logic            nice_req_valid,
   output logic            nice_req_ready,
   input  nice_pkg::word_t nice_req_inst,
   input  nice_pkg::word_t nice_req_rs1,
   input  nice_pkg::word_t nice_req_rs2,
   // cpu response
   output logic            nice_rsp_valid,
   input  logic            nice_rsp_ready,
   output nice_pkg::word_t nice_rsp_rdat,
   output logic            nice_rsp_err,
   // icb command
   output logic            nice_icb_cmd_valid,
   input  logic            nice_icb_cmd_ready,
   output nice_pkg::addr_t nice_icb_cmd_addr,
   output logic            nice_icb_cmd_read,
   output nice_pkg::word_t nice_icb_cmd_wdata,
   output logic [1:0]      nice_icb_cmd_size,
   // icb response
   input  logic            nice_icb_rsp_valid,
   output logic            nice_icb_rsp_ready,
   input  nice_pkg::word_t nice_icb_rsp_rdata,
   input  logic            nice_icb_rsp_err
);

   // controller to datapath
   logic               start;
   nice_pkg::nice_op_e op;
   nice_pkg::addr_t    base_addr;
   logic               done;
   logic               mem_err;
   // memory agent to row buffer
   logic               wr_en;
   nice_pkg::row_idx_t wr_idx;
   nice_pkg::word_t    wr_data;
   nice_pkg::row_idx_t rd_idx;
   nice_pkg::word_t    rd_data;
   nice_pkg::word_t    row_sum;

   // every access is a full word
   assign nice_icb_cmd_size = nice_pkg::ICB_SIZE_WORD;

   //////////////////////////////
   // controller
   //////////////////////////////
   nice_ctrl_fsm i_ctrl_fsm (
      .nice_clk        (nice_clk),
      .reset           (reset),
      .nice_req_valid  (nice_req_valid),
      .nice_req_ready  (nice_req_ready),
      .nice_req_inst   (nice_req_inst),
      .nice_req_rs1    (nice_req_rs1),
      .nice_rsp_valid  (nice_rsp_valid),
      .nice_rsp_ready  (nice_rsp_ready),
      .nice_rsp_rdat   (nice_rsp_rdat),
      .nice_rsp_err    (nice_rsp_err),
      .nice_active     (nice_active),
      .nice_mem_holdup (nice_mem_holdup),
      .start           (start),
      .op              (op),
      .base_addr       (base_addr),
      .done            (done),
      .mem_err         (mem_err),
      .row_sum         (row_sum)
   );

   //////////////////////////////
   // memory agent
   //////////////////////////////
   nice_mem_agent i_mem_agent (
      .nice_clk           (nice_clk),
      .reset              (reset),
      .start              (start),
      .op                 (op),
      .base_addr          (base_addr),
      .done               (done),
      .mem_err            (mem_err),
      .nice_icb_cmd_valid (nice_icb_cmd_valid),
      .nice_icb_cmd_ready (nice_icb_cmd_ready),
      .nice_icb_cmd_addr  (nice_icb_cmd_addr),
      .nice_icb_cmd_read  (nice_icb_cmd_read),
      .nice_icb_cmd_wdata (nice_icb_cmd_wdata),
      .nice_icb_rsp_valid (nice_icb_rsp_valid),
      .nice_icb_rsp_ready (nice_icb_rsp_ready),
      .nice_icb_rsp_rdata (nice_icb_rsp_rdata),
      .nice_icb_rsp_err   (nice_icb_rsp_err),
      .wr_en              (wr_en),
      .wr_idx             (wr_idx),
      .wr_data            (wr_data),
      .rd_idx             (rd_idx),
      .rd_data            (rd_data)
   );

   //////////////////////////////
   // row buffer
   //////////////////////////////
   nice_rowbuf i_rowbuf (
      .nice_clk (nice_clk),
      .reset    (reset),
      .start    (start),
      .op       (op),
      .wr_en    (wr_en),
      .wr_idx   (wr_idx),
      .wr_data  (wr_data),
      .rd_idx   (rd_idx),
      .rd_data  (rd_data),
      .row_sum  (row_sum)
   );

endmodule

// ==== tests/nice_core_assert.sv ====
// nice core handshake checks

`timescale 1ns/1ps

module nice_core_assert (
   input logic                  nice_clk,
   input logic                  reset,
   input nice_pkg::nice_state_e state,
   input logic                  nice_req_valid,
   input logic                  nice_req_ready,
   input logic                  nice_rsp_valid,
   input logic                  nice_rsp_ready,
   input nice_pkg::word_t       nice_rsp_rdat,
   input logic                  nice_rsp_err,
   input logic                  nice_icb_cmd_valid,
   input logic                  nice_icb_cmd_ready,
   input nice_pkg::addr_t       nice_icb_cmd_addr,
   input logic                  nice_icb_cmd_read,
   input nice_pkg::word_t       nice_icb_cmd_wdata
);

   // response held until the cpu takes it
   a_rsp_hold: assert property (@(posedge nice_clk) disable iff (reset)
      nice_rsp_valid && !nice_rsp_ready |=>
         nice_rsp_valid && $stable(nice_rsp_rdat) && $stable(nice_rsp_err))
      else $error("response changed before ready");

   // command held while memory stalls, write data only matters for stores
   a_cmd_hold: assert property (@(posedge nice_clk) disable iff (reset)
      nice_icb_cmd_valid && !nice_icb_cmd_ready |=>
         nice_icb_cmd_valid && $stable(nice_icb_cmd_addr) && $stable(nice_icb_cmd_read)
         && (nice_icb_cmd_read || $stable(nice_icb_cmd_wdata)))
      else $error("memory command changed before ready");

   // an accepted request leaves idle and blocks the next one
   a_req_idle: assert property (@(posedge nice_clk) disable iff (reset)
      nice_req_valid && nice_req_ready |=>
         state != nice_pkg::st_idle && !nice_req_ready)
      else $error("request ready right after a transfer");

   // quiet bus after a reset cycle
   a_reset_quiet: assert property (@(posedge nice_clk)
      reset |=> !nice_icb_cmd_valid && !nice_rsp_valid)
      else $error("valid raised during reset");

endmodule

// ==== tests/tb_nice_core.sv ====
// nice coprocessor testbench

`timescale 1ns/1ps

module tb_nice_core;

   // cycles allowed for any single wait
   localparam int TIMEOUT = 200;

   logic            nice_clk;
   logic            reset;
   logic            nice_active;
   logic            nice_mem_holdup;
   logic            nice_req_valid;
   logic            nice_req_ready;
   nice_pkg::word_t nice_req_inst;
   nice_pkg::word_t nice_req_rs1;
   nice_pkg::word_t nice_req_rs2;
   logic            nice_rsp_valid;
   logic            nice_rsp_ready;
   nice_pkg::word_t nice_rsp_rdat;
   logic            nice_rsp_err;
   logic            nice_icb_cmd_valid;
   logic            nice_icb_cmd_ready;
   nice_pkg::addr_t nice_icb_cmd_addr;
   logic            nice_icb_cmd_read;
   nice_pkg::word_t nice_icb_cmd_wdata;
   logic [1:0]      nice_icb_cmd_size;
   logic            nice_icb_rsp_valid;
   logic            nice_icb_rsp_ready;
   nice_pkg::word_t nice_icb_rsp_rdata;
   logic            nice_icb_rsp_err;

   // memory model contents, faulty words, accesses per instruction
   nice_pkg::word_t mem [nice_pkg::addr_t];
   bit              mem_bad [nice_pkg::addr_t];
   int              hits [nice_pkg::addr_t];
   // in-order responses waiting to go out
   nice_pkg::word_t rdata_q [$];
   logic            rerr_q [$];
   longint          due_q [$];
   longint          cycle;
   logic [31:0]     mem_seed;
   logic [31:0]     drv_seed;
   int              err_cnt;
   int              chk_cnt;
   bit              timed_out;

   nice_core i_dut (
      .nice_clk           (nice_clk),
      .reset              (reset),
      .nice_active        (nice_active),
      .nice_mem_holdup    (nice_mem_holdup),
      .nice_req_valid     (nice_req_valid),
      .nice_req_ready     (nice_req_ready),
      .nice_req_inst      (nice_req_inst),
      .nice_req_rs1       (nice_req_rs1),
      .nice_req_rs2       (nice_req_rs2),
      .nice_rsp_valid     (nice_rsp_valid),
      .nice_rsp_ready     (nice_rsp_ready),
      .nice_rsp_rdat      (nice_rsp_rdat),
      .nice_rsp_err       (nice_rsp_err),
      .nice_icb_cmd_valid (nice_icb_cmd_valid),
      .nice_icb_cmd_ready (nice_icb_cmd_ready),
      .nice_icb_cmd_addr  (nice_icb_cmd_addr),
      .nice_icb_cmd_read  (nice_icb_cmd_read),
      .nice_icb_cmd_wdata (nice_icb_cmd_wdata),
      .nice_icb_cmd_size  (nice_icb_cmd_size),
      .nice_icb_rsp_valid (nice_icb_rsp_valid),
      .nice_icb_rsp_ready (nice_icb_rsp_ready),
      .nice_icb_rsp_rdata (nice_icb_rsp_rdata),
      .nice_icb_rsp_err   (nice_icb_rsp_err)
   );

   // handshake checks inside every nice_core
   bind nice_core nice_core_assert i_assert (
      .nice_clk           (nice_clk),
      .reset              (reset),
      .state              (i_ctrl_fsm.state_q),
      .nice_req_valid     (nice_req_valid),
      .nice_req_ready     (nice_req_ready),
      .nice_rsp_valid     (nice_rsp_valid),
      .nice_rsp_ready     (nice_rsp_ready),
      .nice_rsp_rdat      (nice_rsp_rdat),
      .nice_rsp_err       (nice_rsp_err),
      .nice_icb_cmd_valid (nice_icb_cmd_valid),
      .nice_icb_cmd_ready (nice_icb_cmd_ready),
      .nice_icb_cmd_addr  (nice_icb_cmd_addr),
      .nice_icb_cmd_read  (nice_icb_cmd_read),
      .nice_icb_cmd_wdata (nice_icb_cmd_wdata)
   );

   // 8 ns clock
   initial begin
      nice_clk = 1'b0;
      forever #4 nice_clk = ~nice_clk;
   end

   //////////////////////////////
   // helpers
   //////////////////////////////
   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // background data for words never preloaded
   function automatic nice_pkg::word_t fill_word(input nice_pkg::addr_t a);
      return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
   endfunction

   function automatic int hit_count(input nice_pkg::addr_t a);
      return hits.exists(a) ? hits[a] : 0;
   endfunction

   task automatic check_word(input string name, input nice_pkg::word_t got,
                             input nice_pkg::word_t exp);
      chk_cnt++;
      assert (got === exp) else begin
         err_cnt++;
         $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   //////////////////////////////
   // one instruction
   //////////////////////////////
   task automatic run_inst(input nice_pkg::word_t inst, input nice_pkg::addr_t rs1,
                           input nice_pkg::word_t exp_rdat, input logic exp_err,
                           input int exp_hits);
      int              n;
      bit              got;
      int              total;
      nice_pkg::addr_t a;
      hits.delete();
      @(posedge nice_clk);
      drv_seed = lcg_step(drv_seed);
      nice_req_valid <= 1'b1;
      nice_req_inst  <= inst;
      nice_req_rs1   <= rs1;
      // rs2 is unused by the core
      nice_req_rs2   <= drv_seed;
      // request transfer
      n = 0;
      got = 0;
      while (!got && n < TIMEOUT) begin
         @(posedge nice_clk);
         n++;
         got = nice_req_valid && nice_req_ready;
      end
      nice_req_valid <= 1'b0;
      if (!got) begin
         $display("Error at %0t ns: request %h was never accepted", $time, inst);
         timed_out = 1;
         return;
      end
      // idle follows the request valid
      check_word("nice_active", nice_active, 1'b1);
      // response, with rsp_ready toggling at random
      n = 0;
      got = 0;
      while (!got && n < TIMEOUT) begin
         @(posedge nice_clk);
         n++;
         if (n == 1) begin
            // memory ops hold up the cpu right after the transfer
            check_word("nice_mem_holdup", nice_mem_holdup, exp_hits > 0);
            check_word("nice_active", nice_active, 1'b1);
         end
         if (nice_rsp_valid && nice_rsp_ready) begin
            got = 1;
            check_word("nice_rsp_rdat", nice_rsp_rdat, exp_rdat);
            check_word("nice_rsp_err", nice_rsp_err, exp_err);
            check_word("nice_mem_holdup", nice_mem_holdup, 1'b0);
            check_word("nice_active", nice_active, 1'b1);
         end
         drv_seed = lcg_step(drv_seed);
         nice_rsp_ready <= !got && drv_seed[31];
      end
      if (!got) begin
         $display("Error at %0t ns: no response to request %h", $time, inst);
         timed_out = 1;
         return;
      end
      // one access per row word, none for illegal ops
      total = 0;
      foreach (hits[k]) total += hits[k];
      check_word("memory access count", total, exp_hits);
      if (exp_hits > 0) begin
         for (int i = 0; i < nice_pkg::ROW_LEN; i++) begin
            a = rs1 + i * nice_pkg::WORD_BYTES;
            check_word($sformatf("accesses to %h", a), hit_count(a), 1);
         end
      end
   endtask

   //////////////////////////////
   // memory model
   //////////////////////////////
   always @(posedge nice_clk) begin : mem_model
      nice_pkg::addr_t a;
      mem_seed = lcg_step(mem_seed);
      // responses are never refused
      if (nice_icb_rsp_valid) begin
         check_word("nice_icb_rsp_ready", nice_icb_rsp_ready, 1'b1);
      end
      // front response taken by the core
      if (nice_icb_rsp_valid && nice_icb_rsp_ready) begin
         void'(rdata_q.pop_front());
         void'(rerr_q.pop_front());
         void'(due_q.pop_front());
      end
      if (nice_icb_cmd_valid && nice_icb_cmd_ready) begin
         a = nice_icb_cmd_addr;
         // word access size code
         check_word("nice_icb_cmd_size", nice_icb_cmd_size, 32'd2);
         hits[a] = hit_count(a) + 1;
         if (nice_icb_cmd_read) begin
            rdata_q.push_back(mem.exists(a) ? mem[a] : fill_word(a));
         end else begin
            mem[a] = nice_icb_cmd_wdata;
            rdata_q.push_back('0);
         end
         rerr_q.push_back(mem_bad.exists(a));
         // random extra delay, order kept by the queue
         due_q.push_back(cycle + 1 + mem_seed[28:27]);
      end
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
         nice_icb_rsp_valid <= 1'b1;
         nice_icb_rsp_rdata <= rdata_q[0];
         nice_icb_rsp_err   <= rerr_q[0];
      end else begin
         nice_icb_rsp_valid <= 1'b0;
         nice_icb_rsp_rdata <= '0;
         nice_icb_rsp_err   <= 1'b0;
      end
      // stall commands about one cycle in four
      nice_icb_cmd_ready <= (mem_seed[31:30] != 2'b00);
      cycle++;
   end

   //////////////////////////////
   // main sequence
   //////////////////////////////
   initial begin
      string       line;
      int          fd;
      int          n;
      byte         kind;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      logic [31:0] f4;
      logic [31:0] f5;
      reset              = 1'b1;
      nice_req_valid     = 1'b0;
      nice_req_inst      = '0;
      nice_req_rs1       = '0;
      nice_req_rs2       = '0;
      nice_rsp_ready     = 1'b0;
      nice_icb_cmd_ready = 1'b0;
      nice_icb_rsp_valid = 1'b0;
      nice_icb_rsp_rdata = '0;
      nice_icb_rsp_err   = 1'b0;
      err_cnt   = 0;
      chk_cnt   = 0;
      timed_out = 0;
      cycle     = 0;
      mem_seed  = 32'd70286;
      drv_seed  = lcg_step(32'd70286);
      repeat (5) @(posedge nice_clk);
      // outputs while reset holds
      check_word("nice_req_ready", nice_req_ready, 1'b1);
      check_word("nice_rsp_valid", nice_rsp_valid, 1'b0);
      check_word("nice_icb_cmd_valid", nice_icb_cmd_valid, 1'b0);
      check_word("nice_active", nice_active, 1'b0);
      check_word("nice_mem_holdup", nice_mem_holdup, 1'b0);
      reset <= 1'b0;
      fd = $fopen("tests/nice_core_vectors.txt", "r");
      if (fd == 0) begin
         err_cnt++;
         $display("Error: vector file could not be opened");
      end else begin
         while (!$feof(fd) && !timed_out) begin
            n = $fgets(line, fd);
            // skip blank and comment lines
            if (n > 1 && line[0] != "#") begin
               n = $sscanf(line, "%c %h %h %h %h %h", kind, f1, f2, f3, f4, f5);
               case (kind)
                  "M": begin
                     mem[f1] = f2;
                     if (f3[0]) mem_bad[f1] = 1'b1;
                  end
                  "I": run_inst(f1, f2, f3, f4[0], int'(f5));
                  "C": check_word($sformatf("mem[%h]", f1),
                                  mem.exists(f1) ? mem[f1] : fill_word(f1), f2);
                  default: begin
                     err_cnt++;
                     $display("Error: vector line not understood: %s", line);
                  end
               endcase
            end
         end
         $fclose(fd);
      end
      $display("checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, timed_out);
      if (err_cnt == 0 && !timed_out) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== tests/nice_core_vectors.txt ====
# M addr data err       preload a memory word, err 1 marks a faulty word
# I inst rs1 rdat err n run an instruction, expect rdat, err and n memory accesses
# C addr data           expect a memory word
M 00001000 11111111 0
M 00001004 22222222 0
M 00001008 33333333 0
M 00002000 0000000a 0
M 00002004 fffffff0 0
M 00002008 80000001 0
M 00003000 00000005 0
M 00003004 00000006 1
M 00003008 00000007 0
# lbuf a row, then sbuf it elsewhere
I 0205207b 00001000 00000000 0 3
I 0405207b 00004000 00000000 0 3
C 00004000 11111111
C 00004004 22222222
C 00004008 33333333
# rowsum wraps mod 2^32, then sbuf the updated buffer
I 0c0565fb 00002000 7ffffffb 0 3
I 0405207b 00005000 00000000 0 3
C 00005000 1111111b
C 00005004 22222212
C 00005008 b3333334
# faulty word, then a clean load
I 0205207b 00003000 00000000 1 3
I 0205207b 00001000 00000000 0 3
# unknown func7, unknown opcode
I 0e05207b 00001000 00000000 1 0
I 0205200b 00001000 00000000 1 0
I 0405207b 00006000 00000000 0 3
C 00006000 11111111
C 00006004 22222222
C 00006008 33333333

// ==== filelist.f ====
logic/nice_pkg.sv
logic/nice_ctrl_fsm.sv
logic/nice_mem_agent.sv
logic/nice_rowbuf.sv
logic/nice_core.sv
tests/nice_core_assert.sv
tests/tb_nice_core.sv

// ==== Bender.yml ====
package:
  name: nice_core

sources:
  # rtl
  - logic/nice_pkg.sv
  - logic/nice_ctrl_fsm.sv
  - logic/nice_mem_agent.sv
  - logic/nice_rowbuf.sv
  - logic/nice_core.sv
  # testbench
  - target: test
    files:
      - tests/nice_core_assert.sv
      - tests/tb_nice_core.sv
